//--- vlog.f
common/mbtrain_pkg.sv
common/pt_pkg.sv
common/sb_if.sv
rtl/sb_exchange.sv
mbtrain_seq/speed_ctrl.sv
rtl/vref_sweep.sv
mbtrain_seq/mbtrain_seq.sv
rtl/mbtrain_top.sv
tests/partner_model.sv
tests/tb_mbtrain.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_mbtrain
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ps
PASS_MSG   ?= Everything OK
LINT_FLAGS ?= --lint-only --timing --assert --timescale $(TIMESCALE)
SIM_FLAGS  ?= --binary --timing --assert --timescale $(TIMESCALE) -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_mbtrain.sv
module tb_mbtrain import mbtrain_pkg::*; import pt_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	// six runs, none longer than about 3000 cycles
	localparam int RUNS           = 6;
	localparam int RUN_CYCLES     = 3000;
	localparam int TIMEOUT_CYCLES = RUNS * RUN_CYCLES + 2000;
	// codes 0 to 15 in steps of one
	localparam int SWEEP_CODES    = 16;

	typedef struct packed {
		logic       err;
		speed_t     speed;
		vref_code_t code;
	} outcome_t;

	logic                 clk;
	logic                 i_reset;
	logic                 i_start;
	speed_t               i_highest_common_speed;
	logic                 i_sb_busy;
	logic                 i_sb_rx_valid;
	sb_msg_t              i_sb_rx_msg;
	logic                 i_rx_pt_ack;
	lanes_t               i_rx_lanes_result;
	logic                 i_tx_pt_ack;
	lanes_t               i_tx_lanes_result;
	logic                 o_sb_valid;
	sb_msg_t              o_sb_msg;
	logic [SB_DATA_W-1:0] o_sb_data;
	substate_t            o_substate;
	logic                 o_rx_pt_en;
	vref_code_t           o_vref_code;
	logic                 o_valtrain_sel;
	logic                 o_tx_pt_en;
	speed_t               o_cur_speed;
	logic                 o_mbtrain_done;
	logic                 o_mbtrain_error;

	// per-run partner setup and expected result
	vref_code_t win_lo;
	vref_code_t win_hi;
	int         threshold;
	outcome_t   exp_q;
	int         cycles;
	logic       start_open;
	substate_t  last_sub;
	int         rx_pts;

	mbtrain_top i_dut (
		.clk                   (clk),
		.i_reset               (i_reset),
		.i_start               (i_start),
		.i_highest_common_speed(i_highest_common_speed),
		.i_sb_busy             (i_sb_busy),
		.i_sb_rx_valid         (i_sb_rx_valid),
		.i_sb_rx_msg           (i_sb_rx_msg),
		.i_rx_pt_ack           (i_rx_pt_ack),
		.i_rx_lanes_result     (i_rx_lanes_result),
		.i_tx_pt_ack           (i_tx_pt_ack),
		.i_tx_lanes_result     (i_tx_lanes_result),
		.o_sb_valid            (o_sb_valid),
		.o_sb_msg              (o_sb_msg),
		.o_sb_data             (o_sb_data),
		.o_substate            (o_substate),
		.o_rx_pt_en            (o_rx_pt_en),
		.o_vref_code           (o_vref_code),
		.o_valtrain_sel        (o_valtrain_sel),
		.o_tx_pt_en            (o_tx_pt_en),
		.o_cur_speed           (o_cur_speed),
		.o_mbtrain_done        (o_mbtrain_done),
		.o_mbtrain_error       (o_mbtrain_error)
	);

	partner_model partner_inst (
		.clk              (clk),
		.i_reset          (i_reset),
		.i_win_lo         (win_lo),
		.i_win_hi         (win_hi),
		.i_threshold      (threshold),
		.i_sb_valid       (o_sb_valid),
		.i_sb_msg         (o_sb_msg),
		.o_sb_busy        (i_sb_busy),
		.o_sb_rx_valid    (i_sb_rx_valid),
		.o_sb_rx_msg      (i_sb_rx_msg),
		.i_rx_pt_en       (o_rx_pt_en),
		.i_vref_code      (o_vref_code),
		.o_rx_pt_ack      (i_rx_pt_ack),
		.o_rx_lanes_result(i_rx_lanes_result),
		.i_tx_pt_en       (o_tx_pt_en),
		.i_cur_speed      (o_cur_speed),
		.o_tx_pt_ack      (i_tx_pt_ack),
		.o_tx_lanes_result(i_tx_lanes_result)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_on_error;
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	// expected code, final speed and outcome
	function automatic outcome_t expected_outcome(input vref_code_t lo, input vref_code_t hi,
			input int thr, input speed_t top);
		outcome_t res;
		// eye center is the floor of the mean, mid-scale when nothing passes
		if (lo <= hi)
			res.code = vref_code_t'((int'(lo) + int'(hi)) / 2);
		else
			res.code = 4'd8;
		// speed steps down until the transmitter passes
		if (thr >= int'(top)) begin
			res.err   = 1'b0;
			res.speed = top;
		end else if (thr >= 0) begin
			res.err   = 1'b0;
			res.speed = speed_t'(thr);
		end else begin
			res.err   = 1'b1;
			res.speed = 3'd0;
		end
		return res;
	endfunction

	task automatic check_idle;
		logic [5:0] ctl;
		ctl = {o_sb_valid, o_rx_pt_en, o_tx_pt_en, o_valtrain_sel, o_mbtrain_done,
			o_mbtrain_error};
		assert (ctl == 6'h0 && o_substate == IDLE) else begin
			$display("[FAIL] idle controls: got %h expected %h, o_substate: got %h expected %h",
				ctl, 6'h0, o_substate, IDLE);
			stop_on_error();
		end
	endtask

	task automatic run_training(input vref_code_t lo, input vref_code_t hi, input int thr,
			input speed_t top);
		@(posedge clk);
		check_idle();
		win_lo                 <= lo;
		win_hi                 <= hi;
		threshold              <= thr;
		i_highest_common_speed <= top;
		exp_q                  <= expected_outcome(lo, hi, thr, top);
		i_start                <= 1'b1;
		@(posedge clk);
		i_start <= 1'b0;
		do
			@(posedge clk);
		while (!(o_mbtrain_done || o_mbtrain_error));
		// one cycle in DONE, then back to idle
		repeat (2) @(posedge clk);
	endtask

	initial begin
		i_reset                = 1'b1;
		i_start                = 1'b0;
		i_highest_common_speed = 3'd0;
		win_lo                 = 4'd0;
		win_hi                 = 4'd0;
		threshold              = 0;
		exp_q                  = '0;
		repeat (2) @(posedge clk);
		i_reset <= 1'b0;
		// nothing moves before start
		repeat (4) begin
			@(posedge clk);
			check_idle();
		end
		run_training(4'd4, 4'd10, 5, 3'd5);
		// passes two steps down
		run_training(4'd2, 4'd12, 3, 3'd5);
		// every link-speed test fails
		run_training(4'd0, 4'd15, -1, 3'd3);
		// empty window
		run_training(4'd15, 4'd0, 7, 3'd7);
		run_training(4'd0, 4'd0, 0, 3'd4);
		run_training(4'd9, 4'd15, 6, 3'd7);
		$display("Everything OK");
		$finish;
	end

	// outcome check on the done or error pulse
	always @(posedge clk) begin
		if (!i_reset && (o_mbtrain_done || o_mbtrain_error)) begin
			assert (o_mbtrain_error == exp_q.err) else begin
				$display("[FAIL] o_mbtrain_error: got %h expected %h", o_mbtrain_error, exp_q.err);
				stop_on_error();
			end
			assert (o_vref_code == exp_q.code) else begin
				$display("[FAIL] o_vref_code: got %h expected %h", o_vref_code, exp_q.code);
				stop_on_error();
			end
			assert (o_cur_speed == exp_q.speed) else begin
				$display("[FAIL] o_cur_speed: got %h expected %h", o_cur_speed, exp_q.speed);
				stop_on_error();
			end
		end
	end

	// valid-lane pattern on the first sweep of a run
	// data-lane pattern on the second
	always @(posedge clk) begin
		if (i_reset || i_start) begin
			rx_pts <= 0;
		end else if (o_rx_pt_en) begin
			assert (o_valtrain_sel == (rx_pts < SWEEP_CODES)) else begin
				$display("[FAIL] o_valtrain_sel: got %h expected %h", o_valtrain_sel,
					rx_pts < SWEEP_CODES);
				stop_on_error();
			end
			rx_pts <= rx_pts + 1;
		end
	end

	// sideband rules on every cycle
	always @(posedge clk) begin
		if (i_reset) begin
			start_open <= 1'b0;
			last_sub   <= IDLE;
		end else begin
			assert (!(o_sb_valid && i_sb_busy)) else begin
				$display("request sent while the sideband was busy");
				stop_on_error();
			end
			// vref substates carry the code, the others the speed
			if (o_sb_valid) begin
				assert (o_sb_data == ((o_substate == VALVREF || o_substate == DATAVREF) ?
						SB_DATA_W'(o_vref_code) : SB_DATA_W'(o_cur_speed))) else begin
					$display("[FAIL] o_sb_data: got %h in substate %h", o_sb_data, o_substate);
					stop_on_error();
				end
			end
			if (o_sb_valid && o_sb_msg == START_REQ) begin
				assert (!start_open) else begin
					$display("second start request before the end request");
					stop_on_error();
				end
				start_open <= 1'b1;
			end
			if (o_sb_valid && o_sb_msg == END_REQ) begin
				assert (start_open) else begin
					$display("end request without a start request");
					stop_on_error();
				end
				start_open <= 1'b0;
			end
			if (o_substate != last_sub) begin
				assert (!start_open) else begin
					$display("substate changed before the end request went out");
					stop_on_error();
				end
			end
			last_sub <= o_substate;
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES) begin
				$display("timeout, training did not finish within %0d cycles", TIMEOUT_CYCLES);
				stop_on_error();
			end
		end
	end

endmodule

//--- tests/partner_model.sv
module partner_model import mbtrain_pkg::*; import pt_pkg::*; (
	input  logic       clk,
	input  logic       i_reset,
	// per-run setup
	input  vref_code_t i_win_lo,
	input  vref_code_t i_win_hi,
	input  int         i_threshold,
	// sideband from the DUT
	input  logic       i_sb_valid,
	input  sb_msg_t    i_sb_msg,
	output logic       o_sb_busy,
	output logic       o_sb_rx_valid,
	output sb_msg_t    o_sb_rx_msg,
	// receiver point test
	input  logic       i_rx_pt_en,
	input  vref_code_t i_vref_code,
	output logic       o_rx_pt_ack,
	output lanes_t     o_rx_lanes_result,
	// transmitter point test
	input  logic       i_tx_pt_en,
	input  speed_t     i_cur_speed,
	output logic       o_tx_pt_ack,
	output lanes_t     o_tx_lanes_result
);
	timeunit 1ns;
	timeprecision 1ps;

	integer     seed = 32'h153b;
	logic       sb_pend;
	logic [2:0] sb_wait;
	sb_msg_t    sb_resp;
	logic       rx_pend;
	logic [2:0] rx_wait;
	logic       rx_pass;
	vref_code_t rx_lane;
	logic       tx_pend;
	logic [2:0] tx_wait;
	logic       tx_pass;
	speed_t     tx_lane;

	// quiet link before the first clock edge
	initial begin
		o_sb_busy         = 1'b0;
		o_sb_rx_valid     = 1'b0;
		o_sb_rx_msg       = START_RESP;
		o_rx_pt_ack       = 1'b0;
		o_rx_lanes_result = '0;
		o_tx_pt_ack       = 1'b0;
		o_tx_lanes_result = '0;
	end

	always @(posedge clk) begin
		if (i_reset) begin
			o_sb_busy     <= 1'b0;
			o_sb_rx_valid <= 1'b0;
			o_rx_pt_ack   <= 1'b0;
			o_tx_pt_ack   <= 1'b0;
			sb_pend       <= 1'b0;
			rx_pend       <= 1'b0;
			tx_pend       <= 1'b0;
		end else begin
			// random back-pressure, about one cycle in eight
			o_sb_busy         <= (3'($random(seed)) == 3'd0);
			o_sb_rx_valid     <= 1'b0;
			o_rx_pt_ack       <= 1'b0;
			o_tx_pt_ack       <= 1'b0;
			// junk on the result lanes while no ack
			o_rx_lanes_result <= lanes_t'($random(seed));
			o_tx_lanes_result <= lanes_t'($random(seed));
			// answer each request after a random wait
			if (i_sb_valid) begin
				sb_pend <= 1'b1;
				sb_wait <= 3'($random(seed));
				sb_resp <= (i_sb_msg == START_REQ) ? START_RESP : END_RESP;
			end else if (sb_pend) begin
				if (sb_wait == 3'd0) begin
					o_sb_rx_valid <= 1'b1;
					o_sb_rx_msg   <= sb_resp;
					sb_pend       <= 1'b0;
				end else begin
					sb_wait <= sb_wait - 3'd1;
				end
			end
			// receiver passes inside the window only
			if (i_rx_pt_en) begin
				rx_pend <= 1'b1;
				rx_wait <= 3'($random(seed));
				rx_pass <= (i_vref_code >= i_win_lo) && (i_vref_code <= i_win_hi);
				rx_lane <= i_vref_code;
			end else if (rx_pend) begin
				if (rx_wait == 3'd0) begin
					o_rx_pt_ack       <= 1'b1;
					// a failing code drops one lane
					o_rx_lanes_result <= rx_pass ? '1 : ~(lanes_t'(1) << rx_lane);
					rx_pend           <= 1'b0;
				end else begin
					rx_wait <= rx_wait - 3'd1;
				end
			end
			// transmitter passes at or below the threshold
			if (i_tx_pt_en) begin
				tx_pend <= 1'b1;
				tx_wait <= 3'($random(seed));
				tx_pass <= (int'(i_cur_speed) <= i_threshold);
				tx_lane <= i_cur_speed;
			end else if (tx_pend) begin
				if (tx_wait == 3'd0) begin
					o_tx_pt_ack       <= 1'b1;
					o_tx_lanes_result <= tx_pass ? '1 : ~(lanes_t'(1) << tx_lane);
					tx_pend           <= 1'b0;
				end else begin
					tx_wait <= tx_wait - 3'd1;
				end
			end
		end
	end

endmodule

//--- rtl/mbtrain_top.sv
module mbtrain_top import mbtrain_pkg::*; import pt_pkg::*; (
	input  logic                 clk,
	input  logic                 i_reset,
	input  logic                 i_start,
	input  speed_t               i_highest_common_speed,
	// sideband from the partner
	input  logic                 i_sb_busy,
	input  logic                 i_sb_rx_valid,
	input  sb_msg_t              i_sb_rx_msg,
	// point test results
	input  logic                 i_rx_pt_ack,
	input  lanes_t               i_rx_lanes_result,
	input  logic                 i_tx_pt_ack,
	input  lanes_t               i_tx_lanes_result,
	// sideband to the partner
	output logic                 o_sb_valid,
	output sb_msg_t              o_sb_msg,
	output logic [SB_DATA_W-1:0] o_sb_data,
	output substate_t            o_substate,
	// receiver side analog and test control
	output logic                 o_rx_pt_en,
	output vref_code_t           o_vref_code,
	output logic                 o_valtrain_sel,
	// transmitter test and pll rate
	output logic                 o_tx_pt_en,
	output speed_t               o_cur_speed,
	// outcome
	output logic                 o_mbtrain_done,
	output logic                 o_mbtrain_error
);

	logic load;
	logic degrade;
	logic at_floor;
	logic sweep_go;
	logic sweep_done;

	// sweep engine to arbiter
	sb_if sweep_sb ();

	mbtrain_seq mbtrain_seq_inst (
		.clk              (clk),
		.i_reset          (i_reset),
		.i_start          (i_start),
		.i_cur_speed      (o_cur_speed),
		.i_at_floor       (at_floor),
		.o_sb_valid       (o_sb_valid),
		.o_sb_msg         (o_sb_msg),
		.o_sb_data        (o_sb_data),
		.i_sb_busy        (i_sb_busy),
		.i_sb_rx_valid    (i_sb_rx_valid),
		.i_sb_rx_msg      (i_sb_rx_msg),
		.o_load           (load),
		.o_degrade        (degrade),
		.o_sweep_go       (sweep_go),
		.o_valtrain_sel   (o_valtrain_sel),
		.i_sweep_done     (sweep_done),
		.sweep_sb         (sweep_sb),
		.o_tx_pt_en       (o_tx_pt_en),
		.i_tx_pt_ack      (i_tx_pt_ack),
		.i_tx_lanes_result(i_tx_lanes_result),
		.o_substate       (o_substate),
		.o_mbtrain_done   (o_mbtrain_done),
		.o_mbtrain_error  (o_mbtrain_error)
	);

	speed_ctrl speed_ctrl_inst (
		.clk                   (clk),
		.i_reset               (i_reset),
		.i_load                (load),
		.i_highest_common_speed(i_highest_common_speed),
		.i_degrade             (degrade),
		.o_cur_speed           (o_cur_speed),
		.o_at_floor            (at_floor)
	);

	vref_sweep vref_sweep_inst (
		.clk              (clk),
		.i_reset          (i_reset),
		.i_go             (sweep_go),
		.i_rx_pt_ack      (i_rx_pt_ack),
		.i_rx_lanes_result(i_rx_lanes_result),
		.o_rx_pt_en       (o_rx_pt_en),
		.o_vref_code      (o_vref_code),
		.o_done           (sweep_done),
		.sb               (sweep_sb)
	);

endmodule

//--- mbtrain_seq/mbtrain_seq.sv
module mbtrain_seq import mbtrain_pkg::*; import pt_pkg::*; (
	input  logic                 clk,
	input  logic                 i_reset,
	input  logic                 i_start,
	input  speed_t               i_cur_speed,
	input  logic                 i_at_floor,
	// sideband toward the partner
	output logic                 o_sb_valid,
	output sb_msg_t              o_sb_msg,
	output logic [SB_DATA_W-1:0] o_sb_data,
	input  logic                 i_sb_busy,
	input  logic                 i_sb_rx_valid,
	input  sb_msg_t              i_sb_rx_msg,
	// speed register
	output logic                 o_load,
	output logic                 o_degrade,
	// vref sweep
	output logic                 o_sweep_go,
	output logic                 o_valtrain_sel,
	input  logic                 i_sweep_done,
	sb_if.slave                  sweep_sb,
	// transmit point test
	output logic                 o_tx_pt_en,
	input  logic                 i_tx_pt_ack,
	input  lanes_t               i_tx_lanes_result,
	// status
	output substate_t            o_substate,
	output logic                 o_mbtrain_done,
	output logic                 o_mbtrain_error
);

	typedef enum logic [2:0] {
		PH_KICK,
		PH_START,
		PH_WORK,
		PH_PTWAIT,
		PH_END,
		PH_ENDW
	} phase_t;

	substate_t substate;
	phase_t    phase;
	logic      vref_active;
	logic      spd_active;
	logic      ex_go;
	logic      ex_done;
	sb_msg_t   ex_msg;
	logic      end_done;
	logic      ls_pass;

	sb_if seq_sb ();

	// own exchanges carry the current speed
	sb_exchange #(
		.payload_t(speed_t)
	) sb_exchange_inst (
		.clk      (clk),
		.i_reset  (i_reset),
		.i_go     (ex_go),
		.i_req_msg(ex_msg),
		.i_payload(i_cur_speed),
		.o_done   (ex_done),
		.sb       (seq_sb)
	);

	assign vref_active = (substate == VALVREF) || (substate == DATAVREF);
	assign spd_active  = (substate == SPEEDIDLE) || (substate == LINKSPEED);

	// sideband mux, sweep owns the link in the vref substates
	assign o_sb_valid = vref_active ? sweep_sb.valid : seq_sb.valid;
	assign o_sb_msg   = vref_active ? sweep_sb.msg : seq_sb.msg;
	assign o_sb_data  = vref_active ? sweep_sb.data : seq_sb.data;
	// parked link sees a busy channel and no traffic
	assign sweep_sb.busy     = vref_active ? i_sb_busy : 1'b1;
	assign sweep_sb.rx_valid = vref_active && i_sb_rx_valid;
	assign sweep_sb.rx_msg   = i_sb_rx_msg;
	assign seq_sb.busy       = vref_active || i_sb_busy;
	assign seq_sb.rx_valid   = !vref_active && i_sb_rx_valid;
	assign seq_sb.rx_msg     = i_sb_rx_msg;

	// substate strobes
	assign ex_go          = spd_active && (phase == PH_KICK || phase == PH_END);
	assign ex_msg         = (phase == PH_END) ? END_REQ : START_REQ;
	assign o_sweep_go     = vref_active && (phase == PH_KICK);
	assign o_valtrain_sel = (substate == VALVREF);
	assign o_tx_pt_en     = (substate == LINKSPEED) && (phase == PH_WORK);
	assign o_load         = (substate == IDLE) && i_start;
	assign o_substate     = substate;

	// step down here so SPEEDIDLE sends the new rate
	assign end_done  = spd_active && (phase == PH_ENDW) && ex_done;
	assign o_degrade = (substate == LINKSPEED) && end_done && !ls_pass && !i_at_floor;

	// link-speed verdict
	always_ff @(posedge clk) begin
		if (phase == PH_PTWAIT && i_tx_pt_ack)
			ls_pass <= &i_tx_lanes_result;
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			substate        <= IDLE;
			phase           <= PH_KICK;
			o_mbtrain_done  <= 1'b0;
			o_mbtrain_error <= 1'b0;
		end else begin
			o_mbtrain_done  <= 1'b0;
			o_mbtrain_error <= 1'b0;
			case (substate)
				IDLE: begin
					if (i_start) begin
						substate <= VALVREF;
						phase    <= PH_KICK;
					end
				end
				VALVREF, DATAVREF: begin
					// sweep runs its own start/end exchanges
					if (phase == PH_KICK) begin
						phase <= PH_WORK;
					end else if (i_sweep_done) begin
						substate <= (substate == VALVREF) ? DATAVREF : SPEEDIDLE;
						phase    <= PH_KICK;
					end
				end
				SPEEDIDLE, LINKSPEED: begin
					case (phase)
						PH_KICK: phase <= PH_START;
						PH_START: begin
							if (ex_done)
								phase <= (substate == LINKSPEED) ? PH_WORK : PH_END;
						end
						PH_WORK: phase <= PH_PTWAIT;
						PH_PTWAIT: begin
							if (i_tx_pt_ack)
								phase <= PH_END;
						end
						PH_END: phase <= PH_ENDW;
						default: begin
							if (end_done) begin
								phase <= PH_KICK;
								if (substate == SPEEDIDLE) begin
									substate <= LINKSPEED;
								end else if (ls_pass) begin
									substate       <= DONE;
									o_mbtrain_done <= 1'b1;
								end else if (i_at_floor) begin
									substate        <= DONE;
									o_mbtrain_error <= 1'b1;
								end else begin
									// retry one step slower
									substate <= SPEEDIDLE;
								end
							end
						end
					endcase
				end
				default: substate <= IDLE;
			endcase
		end
	end

	// one outcome per run
	assert property (@(posedge clk) disable iff (i_reset)
		!(o_mbtrain_done && o_mbtrain_error));
	// back to idle right after the outcome
	assert property (@(posedge clk) disable iff (i_reset)
		(o_mbtrain_done || o_mbtrain_error) |=> (o_substate == IDLE));

endmodule

//--- rtl/vref_sweep.sv
module vref_sweep import mbtrain_pkg::*; import pt_pkg::*; (
	input  logic       clk,
	input  logic       i_reset,
	input  logic       i_go,
	input  logic       i_rx_pt_ack,
	input  lanes_t     i_rx_lanes_result,
	output logic       o_rx_pt_en,
	output vref_code_t o_vref_code,
	output logic       o_done,
	sb_if.master       sb
);

	typedef enum logic [2:0] {
		SW_IDLE,
		SW_START,
		SW_PT,
		SW_ACK,
		SW_PICK,
		SW_END,
		SW_ENDW
	} sw_state_t;

	sw_state_t                 state;
	vref_code_t                code;
	vref_code_t                first_pass;
	vref_code_t                last_pass;
	logic                      found;
	logic                      pt_pass;
	logic [$bits(vref_code_t):0] code_sum;
	logic                      ex_go;
	logic                      ex_done;
	sb_msg_t                   ex_msg;
	logic                      pt_pending;

	// start exchange on go, end exchange once the code is picked
	assign ex_go  = (state == SW_IDLE && i_go) || (state == SW_END);
	assign ex_msg = (state == SW_END) ? END_REQ : START_REQ;

	sb_exchange #(
		.payload_t(vref_code_t)
	) sb_exchange_inst (
		.clk      (clk),
		.i_reset  (i_reset),
		.i_go     (ex_go),
		.i_req_msg(ex_msg),
		.i_payload(code),
		.o_done   (ex_done),
		.sb       (sb)
	);

	// one receiver point test per code
	assign o_rx_pt_en  = (state == SW_PT);
	assign o_vref_code = code;
	// all lanes must pass
	assign pt_pass     = (state == SW_ACK) && i_rx_pt_ack && (&i_rx_lanes_result);
	// eye center, floor of the mean
	assign code_sum    = {1'b0, first_pass} + {1'b0, last_pass};

	// edges of the passing window
	always_ff @(posedge clk) begin
		if (pt_pass) begin
			last_pass <= code;
			if (!found)
				first_pass <= code;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state  <= SW_IDLE;
			code   <= VREF_DEFAULT;
			found  <= 1'b0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				SW_IDLE: begin
					if (i_go) begin
						state <= SW_START;
						found <= 1'b0;
					end
				end
				SW_START: begin
					if (ex_done) begin
						code  <= VREF_MIN;
						state <= SW_PT;
					end
				end
				SW_PT: state <= SW_ACK;
				SW_ACK: begin
					if (i_rx_pt_ack) begin
						if (pt_pass)
							found <= 1'b1;
						// last code tested, go pick
						if (code > VREF_MAX - VREF_STEP) begin
							state <= SW_PICK;
						end else begin
							code  <= code + VREF_STEP;
							state <= SW_PT;
						end
					end
				end
				SW_PICK: begin
					code  <= found ? code_sum[$bits(vref_code_t):1] : VREF_DEFAULT;
					state <= SW_END;
				end
				SW_END: state <= SW_ENDW;
				SW_ENDW: begin
					if (ex_done) begin
						o_done <= 1'b1;
						state  <= SW_IDLE;
					end
				end
				default: state <= SW_IDLE;
			endcase
		end
	end

	// outstanding receiver test
	always_ff @(posedge clk) begin
		if (i_reset)
			pt_pending <= 1'b0;
		else if (o_rx_pt_en)
			pt_pending <= 1'b1;
		else if (i_rx_pt_ack)
			pt_pending <= 1'b0;
	end

	// no new enable until the responder acks
	assert property (@(posedge clk) disable iff (i_reset) !(o_rx_pt_en && pt_pending));

endmodule

//--- mbtrain_seq/speed_ctrl.sv
module speed_ctrl import mbtrain_pkg::*; (
	input  logic   clk,
	input  logic   i_reset,
	input  logic   i_load,
	input  speed_t i_highest_common_speed,
	input  logic   i_degrade,
	output speed_t o_cur_speed,
	output logic   o_at_floor
);

	// operating speed register
	// start of training takes the negotiated rate
	// each failed link-speed pass drops one step
	always_ff @(posedge clk) begin
		if (i_reset)
			o_cur_speed <= SPEED_MIN;
		else if (i_load)
			o_cur_speed <= i_highest_common_speed;
		else if (i_degrade && !o_at_floor)
			o_cur_speed <= o_cur_speed - speed_t'(1);
	end

	// lowest rate reached
	// sequencer errors out instead of degrading
	assign o_at_floor = (o_cur_speed == SPEED_MIN);

	// sequencer must not ask for a step below the floor
	assert property (@(posedge clk) disable iff (i_reset) i_degrade |-> !o_at_floor);

endmodule

//--- rtl/sb_exchange.sv
module sb_exchange import mbtrain_pkg::*; #(
	parameter type payload_t = speed_t
) (
	input  logic     clk,
	input  logic     i_reset,
	input  logic     i_go,
	input  sb_msg_t  i_req_msg,
	input  payload_t i_payload,
	output logic     o_done,
	sb_if.master     sb
);

	typedef enum logic [1:0] {
		EX_IDLE,
		EX_REQ,
		EX_WAIT
	} ex_state_t;

	ex_state_t state;
	sb_msg_t   req_msg_q;
	payload_t  payload_q;
	sb_msg_t   resp_msg;
	logic      resp_hit;

	// request fields captured on go
	always_ff @(posedge clk) begin
		if (state == EX_IDLE && i_go) begin
			req_msg_q <= i_req_msg;
			payload_q <= i_payload;
		end
	end

	// fire as soon as the channel is free
	assign sb.valid = (state == EX_REQ) && !sb.busy;
	assign sb.msg   = req_msg_q;
	// payload zero-extended into the data field
	assign sb.data  = SB_DATA_W'(payload_q);

	// only the matching response counts
	assign resp_msg = sb_resp_for(req_msg_q);
	assign resp_hit = (state == EX_WAIT) && sb.rx_valid && (sb.rx_msg == resp_msg);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state  <= EX_IDLE;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				EX_IDLE: begin
					if (i_go)
						state <= EX_REQ;
				end
				EX_REQ: begin
					// request leaves this cycle
					if (!sb.busy)
						state <= EX_WAIT;
				end
				EX_WAIT: begin
					if (resp_hit) begin
						state  <= EX_IDLE;
						o_done <= 1'b1;
					end
				end
				default: state <= EX_IDLE;
			endcase
		end
	end

	// a go while an exchange is still open would be lost
	assert property (@(posedge clk) disable iff (i_reset) i_go |-> (state == EX_IDLE));

endmodule

//--- common/sb_if.sv
interface sb_if import mbtrain_pkg::*; ();

	// request toward the partner
	logic                 valid;
	sb_msg_t              msg;
	logic [SB_DATA_W-1:0] data;

	// channel back-pressure
	logic                 busy;

	// messages heard from the partner
	logic                 rx_valid;
	sb_msg_t              rx_msg;

	// exchange engine side
	modport master (
		output valid, msg, data,
		input  busy, rx_valid, rx_msg
	);

	// arbiter side
	modport slave (
		input  valid, msg, data,
		output busy, rx_valid, rx_msg
	);

endinterface

//--- common/pt_pkg.sv
package pt_pkg;

	// main-band lanes checked per point test
	localparam int LANES = 16;

	// one pass bit per lane
	typedef logic [LANES-1:0] lanes_t;

	// receiver reference voltage control word
	typedef logic [3:0] vref_code_t;

	// sweep range and step
	localparam vref_code_t VREF_MIN  = 4'd0;
	localparam vref_code_t VREF_MAX  = 4'd15;
	localparam vref_code_t VREF_STEP = 4'd1;

	// mid-scale code, used when nothing passes
	localparam vref_code_t VREF_DEFAULT = 4'd8;

endpackage

//--- common/mbtrain_pkg.sv
package mbtrain_pkg;

	// main-band training substates
	// same code goes out on the substate field
	typedef enum logic [3:0] {
		IDLE      = 4'h0,
		VALVREF   = 4'h1,
		DATAVREF  = 4'h2,
		SPEEDIDLE = 4'h3,
		LINKSPEED = 4'h4,
		DONE      = 4'h5
	} substate_t;

	// sideband message codes
	typedef enum logic [3:0] {
		START_REQ  = 4'h1,
		START_RESP = 4'h2,
		END_REQ    = 4'h3,
		END_RESP   = 4'h4
	} sb_msg_t;

	// speed index, 0 is the slowest rate
	typedef logic [2:0] speed_t;

	// floor of the degrade ladder
	localparam speed_t SPEED_MIN = 3'd0;
	// sideband data field
	localparam int     SB_DATA_W = 16;

	// response that closes a request
	function automatic sb_msg_t sb_resp_for(input sb_msg_t req);
		sb_msg_t resp;
		case (req)
			START_REQ: resp = START_RESP;
			default:   resp = END_RESP;
		endcase
		return resp;
	endfunction

endpackage
